//--- include/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

typedef struct packed {
    logic [4:0]      rd;
    logic [31:0]     imm;
    rv_pkg::alu_op_e alu_op;
    logic            alu_src;
    logic            jal;
    logic            jalr;
    logic            branch;
    logic            bne;
    logic            mem_ren;
    logic            mem_wen;
    logic            mem_to_reg;
    logic            reg_wen;
    logic            illegal;
} exp_dec_t;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

// also serves load and jalr through opc.
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
    input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, rv_pkg::F3_SW, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_pkg::OPC_LUI};
endfunction

// expected registered bundle for one instruction.
function automatic exp_dec_t exp_decode(input logic [31:0] inst);
    exp_dec_t e;
    logic [2:0] f3;
    logic       b30;
    e   = '0;
    f3  = inst[14:12];
    b30 = inst[30];
    case (inst[6:0])
        rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
            e.reg_wen = 1'b1;
            e.alu_src = (inst[6:0] == rv_pkg::OPC_OP_IMM);
            e.imm     = e.alu_src ? {{20{inst[31]}}, inst[31:20]} : 32'd0;
            case (f3)
                3'd0:    e.alu_op = (b30 && !e.alu_src) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'd1:    e.alu_op = rv_pkg::ALU_SLL;
                3'd2:    e.alu_op = rv_pkg::ALU_SLT;
                3'd3:    e.alu_op = rv_pkg::ALU_SLTU;
                3'd4:    e.alu_op = rv_pkg::ALU_XOR;
                3'd5:    e.alu_op = b30 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'd6:    e.alu_op = rv_pkg::ALU_OR;
                default: e.alu_op = rv_pkg::ALU_AND;
            endcase
        end
        rv_pkg::OPC_LOAD: begin
            {e.reg_wen, e.alu_src, e.mem_ren, e.mem_to_reg} = 4'b1111;
            e.imm = {{20{inst[31]}}, inst[31:20]};
        end
        rv_pkg::OPC_STORE: begin
            {e.alu_src, e.mem_wen} = 2'b11;
            e.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        end
        rv_pkg::OPC_BRANCH: begin
            e.branch = 1'b1;
            e.bne    = (f3 == rv_pkg::F3_BNE);
            e.alu_op = rv_pkg::ALU_SUB;
            e.imm    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        rv_pkg::OPC_JAL: begin
            {e.jal, e.reg_wen} = 2'b11;
            e.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        rv_pkg::OPC_JALR: begin
            {e.jalr, e.reg_wen, e.alu_src} = 3'b111;
            e.imm = {{20{inst[31]}}, inst[31:20]};
        end
        rv_pkg::OPC_LUI: begin
            {e.reg_wen, e.alu_src} = 2'b11;
            e.alu_op = rv_pkg::ALU_PASS_B;
            e.imm    = {inst[31:12], 12'd0};
        end
        default: e.illegal = 1'b1;
    endcase
    e.rd = e.reg_wen ? inst[11:7] : 5'd0;
    return e;
endfunction

`endif

//--- bench/tb_decode_top.sv
`default_nettype none

module tb_decode_top;
    import rv_pkg::*;

    `include "tb_decode_model.svh"

    logic        clk;
    logic        rst_n;
    logic        stall_i;
    logic        flush_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic        wb_wen_i;
    logic [4:0]  wb_rd_i;
    logic [31:0] wb_data_i;
    logic [4:0]  rd_o;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic [31:0] imm_o;
    logic [31:0] pc_o;
    logic        alu_src_o, jal_o, jalr_o, branch_o, bne_o;
    logic        mem_ren_o, mem_wen_o, mem_to_reg_o, reg_wen_o, illegal_o;
    alu_op_e     alu_op_o;

    logic [31:0] reg_model [32];  // expected register contents.
    logic [31:0] next_pc;
    int          cycles = 0;
    int          errors = 0;

    rv_decode_top #(
        .NUM_REGS (32)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .wb_wen_i     (wb_wen_i),
        .wb_rd_i      (wb_rd_i),
        .wb_data_i    (wb_data_i),
        .rd_o         (rd_o),
        .rs1_data_o   (rs1_data_o),
        .rs2_data_o   (rs2_data_o),
        .imm_o        (imm_o),
        .pc_o         (pc_o),
        .alu_src_o    (alu_src_o),
        .jal_o        (jal_o),
        .jalr_o       (jalr_o),
        .branch_o     (branch_o),
        .bne_o        (bne_o),
        .mem_ren_o    (mem_ren_o),
        .mem_wen_o    (mem_wen_o),
        .mem_to_reg_o (mem_to_reg_o),
        .reg_wen_o    (reg_wen_o),
        .illegal_o    (illegal_o),
        .alu_op_o     (alu_op_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "check failed");
        end
    endtask

    // returns 5 units after the n-th rising edge.
    task automatic wait_cycles(input int n);
        int target;
        int waited;
        target = cycles + n;
        waited = 0;
        while (cycles < target && waited < n * 40 + 100) begin
            #1;
            waited++;
        end
        if (cycles < target) begin
            $display("Timeout: no clock edge arrived while waiting for %0d cycles", n);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end else begin
            #4;
        end
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        wb_wen_i  = 1'b1;
        wb_rd_i   = rd;
        wb_data_i = data;
        wait_cycles(1);
        wb_wen_i = 1'b0;
        if (rd != 5'd0) reg_model[rd] = data;  // x0 stays zero.
    endtask

    task automatic issue(input logic [31:0] inst);
        inst_i  = inst;
        pc_i    = next_pc;
        next_pc = next_pc + 32'd4;
        wait_cycles(1);
    endtask

    task automatic check_outputs(input exp_dec_t e, input logic [31:0] d1,
                                 input logic [31:0] d2, input logic [31:0] pc,
                                 input string tag);
        check(rd_o, e.rd, {tag, ": rd"});
        check(rs1_data_o, d1, {tag, ": rs1 data"});
        check(rs2_data_o, d2, {tag, ": rs2 data"});
        check(imm_o, e.imm, {tag, ": imm"});
        check(pc_o, pc, {tag, ": pc"});
        check(alu_op_o, e.alu_op, {tag, ": alu op"});
        check({alu_src_o, jal_o, jalr_o, branch_o, bne_o,
               mem_ren_o, mem_wen_o, mem_to_reg_o, reg_wen_o, illegal_o},
              {e.alu_src, e.jal, e.jalr, e.branch, e.bne,
               e.mem_ren, e.mem_wen, e.mem_to_reg, e.reg_wen, e.illegal},
              {tag, ": control bits"});
    endtask

    task automatic run_and_check(input logic [31:0] inst, input string tag);
        exp_dec_t    e;
        logic [31:0] d1, d2, pc;
        e  = exp_decode(inst);
        d1 = reg_model[inst[19:15]];
        d2 = reg_model[inst[24:20]];
        pc = next_pc;
        issue(inst);
        check_outputs(e, d1, d2, pc, tag);
    endtask

    task automatic test_reset();
        exp_dec_t zero;
        zero = '0;
        check_outputs(zero, 32'd0, 32'd0, 32'd0, "reset");
    endtask

    task automatic test_alu();
        logic [4:0]  rs1, rs2, rd, sh;
        logic [11:0] imm;
        for (int r = 1; r < 32; r++) begin
            write_reg(5'(r), $urandom);
        end
        for (int f = 0; f < 8; f++) begin
            rs1 = 5'($urandom);
            rs2 = 5'($urandom);
            rd  = 5'($urandom);
            run_and_check(enc_r(7'h00, rs2, rs1, 3'(f), rd), "r-type alu");
        end
        rd = 5'($urandom);
        run_and_check(enc_r(7'h20, 5'd3, 5'd7, F3_ADD, rd), "sub");
        check(alu_op_o, ALU_SUB, "sub op");
        run_and_check(enc_r(7'h20, 5'd9, 5'd4, F3_SR, rd), "sra");
        check(alu_op_o, ALU_SRA, "sra op");
        for (int f = 0; f < 8; f++) begin
            rs1 = 5'($urandom);
            rd  = 5'($urandom);
            sh  = 5'($urandom);
            imm = (f == 1 || f == 5) ? {7'h00, sh} : 12'($urandom);
            run_and_check(enc_i(imm, rs1, 3'(f), rd, OPC_OP_IMM), "i-type alu");
        end
        sh = 5'($urandom);
        run_and_check(enc_i({7'h20, sh}, 5'd11, F3_SR, 5'd12, OPC_OP_IMM), "srai");
        check(alu_op_o, ALU_SRA, "srai op");
        run_and_check(enc_i({7'h20, sh}, 5'd11, F3_ADD, 5'd12, OPC_OP_IMM), "addi bit30");
        check(alu_op_o, ALU_ADD, "addi never sub");
    endtask

    task automatic test_other();
        logic [4:0]  rs1, rs2, rd;
        logic [11:0] imm;
        logic [12:0] bimm;
        logic [20:0] jimm;
        logic [19:0] uimm;
        for (int k = 0; k < 4; k++) begin
            rs1  = 5'($urandom);
            rs2  = 5'($urandom);
            rd   = 5'($urandom);
            imm  = 12'($urandom);
            bimm = {12'($urandom), 1'b0};
            jimm = {20'($urandom), 1'b0};
            uimm = 20'($urandom);
            run_and_check(enc_i(imm, rs1, F3_LW, rd, OPC_LOAD), "lw");
            check(imm_o, {{20{imm[11]}}, imm}, "lw imm sign");
            run_and_check(enc_s(imm, rs2, rs1), "sw");
            check(imm_o, {{20{imm[11]}}, imm}, "sw imm sign");
            run_and_check(enc_b(bimm, rs2, rs1, F3_BEQ), "beq");
            check(bne_o, 1'b0, "beq clears bne");
            check(imm_o, {{19{bimm[12]}}, bimm}, "beq imm sign");
            run_and_check(enc_b(bimm, rs2, rs1, F3_BNE), "bne");
            check({branch_o, bne_o}, 2'b11, "bne bits");
            run_and_check(enc_j(jimm, rd), "jal");
            check(imm_o, {{11{jimm[20]}}, jimm}, "jal imm sign");
            run_and_check(enc_i(imm, rs1, F3_JALR, rd, OPC_JALR), "jalr");
            check(imm_o, {{20{imm[11]}}, imm}, "jalr imm sign");
            run_and_check(enc_u(uimm, rd), "lui");
            check(imm_o, {uimm, 12'd0}, "lui imm");
            run_and_check({25'($urandom), 7'b1111111}, "undefined opcode");
            check({rd_o, illegal_o, reg_wen_o}, 7'b0000010, "illegal bubble");
        end
    endtask

    task automatic test_stall();
        logic [31:0] inst;
        exp_dec_t    e;
        logic [31:0] d1, d2, pc;
        inst = enc_r(7'h00, 5'd6, 5'd5, F3_XOR, 5'd10);
        e    = exp_decode(inst);
        d1   = reg_model[5];
        d2   = reg_model[6];
        pc   = next_pc;
        run_and_check(inst, "before stall");
        stall_i = 1'b1;
        for (int k = 0; k < 3; k++) begin
            inst_i = enc_u(20'($urandom), 5'($urandom));  // inputs keep moving.
            pc_i   = $urandom;
            wait_cycles(1);
            check_outputs(e, d1, d2, pc, "stall hold");
        end
        stall_i = 1'b0;
    endtask

    task automatic test_flush();
        logic [31:0] inst;
        exp_dec_t    b;
        exp_dec_t    full;
        logic [31:0] d1, d2, pc;
        inst  = enc_i(12'($urandom), 5'd8, F3_LW, 5'd14, OPC_LOAD);
        full  = exp_decode(inst);
        b     = '0;
        b.imm = full.imm;  // bubble keeps the immediate.
        d1    = reg_model[inst[19:15]];
        d2    = reg_model[inst[24:20]];
        pc    = next_pc;
        flush_i = 1'b1;
        issue(inst);
        check_outputs(b, d1, d2, pc, "flush");
        stall_i = 1'b1;
        inst_i  = enc_r(7'h00, 5'd1, 5'd2, F3_OR, 5'd3);
        pc_i    = $urandom;
        wait_cycles(1);
        check_outputs(b, d1, d2, pc, "stall over flush");
        stall_i = 1'b0;
        flush_i = 1'b0;
    endtask

    task automatic test_bypass();
        logic [4:0]  rs;
        logic [31:0] val, inst, pc;
        rs   = 5'(1 + $urandom % 31);
        val  = $urandom;
        inst = enc_r(7'h00, rs, rs, F3_ADD, 5'd20);
        pc   = next_pc;
        wb_wen_i  = 1'b1;
        wb_rd_i   = rs;
        wb_data_i = val;
        issue(inst);
        wb_wen_i      = 1'b0;
        reg_model[rs] = val;
        check_outputs(exp_decode(inst), val, val, pc, "write-through");
        run_and_check(inst, "stored after write");
        write_reg(5'd0, $urandom);
        run_and_check(enc_r(7'h00, 5'd0, 5'd0, F3_OR, 5'd21), "x0 read");
        check(rs1_data_o, 32'd0, "x0 reads zero");
        wb_wen_i  = 1'b1;
        wb_rd_i   = 5'd0;
        wb_data_i = 32'hffff_ffff;
        run_and_check(enc_i(12'h001, 5'd0, F3_ADD, 5'd22, OPC_OP_IMM), "x0 no bypass");
        wb_wen_i = 1'b0;
    endtask

    initial begin
        void'($urandom(81));
        rst_n     = 1'b0;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        inst_i    = 32'h0000_0013;  // nop.
        pc_i      = '0;
        wb_wen_i  = 1'b0;
        wb_rd_i   = '0;
        wb_data_i = '0;
        next_pc   = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            reg_model[r] = '0;
        end
        wait_cycles(10);
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_other();
        test_stall();
        test_flush();
        test_bypass();
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_id_stage.sv
src/rv_decode_top.sv
bench/tb_decode_top.sv

//--- src/rv_decode_top.sv
`default_nettype none

module rv_decode_top #(
    parameter int NUM_REGS = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic [31:0]     inst_i,
    input  logic [31:0]     pc_i,
    input  logic            wb_wen_i,
    input  logic [4:0]      wb_rd_i,
    input  logic [31:0]     wb_data_i,
    output logic [4:0]      rd_o,
    output logic [31:0]     rs1_data_o,
    output logic [31:0]     rs2_data_o,
    output logic [31:0]     imm_o,
    output logic [31:0]     pc_o,
    output logic            alu_src_o,
    output logic            jal_o,
    output logic            jalr_o,
    output logic            branch_o,
    output logic            bne_o,
    output logic            mem_ren_o,
    output logic            mem_wen_o,
    output logic            mem_to_reg_o,
    output logic            reg_wen_o,
    output logic            illegal_o,
    output rv_pkg::alu_op_e alu_op_o
);

    logic [4:0]  rs1_addr, rs2_addr;
    logic [31:0] rs1_data, rs2_data;  // same-cycle read data.

    rv_id_stage u_id_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rd_o         (rd_o),
        .rs1_data_o   (rs1_data_o),
        .rs2_data_o   (rs2_data_o),
        .imm_o        (imm_o),
        .pc_o         (pc_o),
        .alu_src_o    (alu_src_o),
        .jal_o        (jal_o),
        .jalr_o       (jalr_o),
        .branch_o     (branch_o),
        .bne_o        (bne_o),
        .mem_ren_o    (mem_ren_o),
        .mem_wen_o    (mem_wen_o),
        .mem_to_reg_o (mem_to_reg_o),
        .reg_wen_o    (reg_wen_o),
        .illegal_o    (illegal_o),
        .alu_op_o     (alu_op_o)
    );

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_rd_i    (wb_rd_i),
        .wb_wen_i   (wb_wen_i),
        .wb_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

`default_nettype wire

//--- src/rv_decoder.sv
`default_nettype none

module rv_decoder (
    input  logic [31:0]     inst_i,
    output logic [4:0]      rs1_o,
    output logic [4:0]      rs2_o,
    output logic [4:0]      rd_o,
    output logic [31:0]     imm_o,
    output logic            alu_src_o,
    output logic            jal_o,
    output logic            jalr_o,
    output logic            branch_o,
    output logic            bne_o,
    output logic            mem_ren_o,
    output logic            mem_wen_o,
    output logic            mem_to_reg_o,
    output logic            reg_wen_o,
    output logic            illegal_o,
    output rv_pkg::alu_op_e alu_op_o
);
    import rv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            bit30;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

    // sub only for register ops, sra for both.
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic b30,
                                        input logic is_reg);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = (b30 && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = b30 ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign bit30  = inst_i[30];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign rd_o   = reg_wen_o ? inst_i[11:7] : 5'd0;  // bubble has no rd.

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                    1'b0};
    assign imm_u = {inst_i[31:12], 12'd0};

    always_comb begin
        imm_o        = '0;
        alu_op_o     = ALU_ADD;
        alu_src_o    = 1'b0;
        jal_o        = 1'b0;
        jalr_o       = 1'b0;
        branch_o     = 1'b0;
        bne_o        = 1'b0;
        mem_ren_o    = 1'b0;
        mem_wen_o    = 1'b0;
        mem_to_reg_o = 1'b0;
        reg_wen_o    = 1'b0;
        illegal_o    = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_wen_o = 1'b1;
                alu_op_o  = alu_sel(funct3, bit30, 1'b1);
            end
            OPC_OP_IMM: begin
                reg_wen_o = 1'b1;
                alu_src_o = 1'b1;
                imm_o     = imm_i;
                alu_op_o  = alu_sel(funct3, bit30, 1'b0);
            end
            OPC_LOAD: begin
                reg_wen_o    = 1'b1;
                alu_src_o    = 1'b1;
                mem_ren_o    = 1'b1;
                mem_to_reg_o = 1'b1;
                imm_o        = imm_i;
            end
            OPC_STORE: begin
                alu_src_o = 1'b1;
                mem_wen_o = 1'b1;
                imm_o     = imm_s;
            end
            OPC_BRANCH: begin
                branch_o = 1'b1;
                bne_o    = (funct3 == F3_BNE);
                alu_op_o = ALU_SUB;  // compare by subtract.
                imm_o    = imm_b;
            end
            OPC_JAL: begin
                jal_o     = 1'b1;
                reg_wen_o = 1'b1;
                imm_o     = imm_j;
            end
            OPC_JALR: begin
                jalr_o    = 1'b1;
                reg_wen_o = 1'b1;
                alu_src_o = 1'b1;
                imm_o     = imm_i;
            end
            OPC_LUI: begin
                reg_wen_o = 1'b1;
                alu_src_o = 1'b1;
                alu_op_o  = ALU_PASS_B;
                imm_o     = imm_u;
            end
            default: illegal_o = 1'b1;
        endcase
    end

    // at most one kind of control transfer per instruction.
    a_one_transfer: assert final ($onehot0({jal_o, jalr_o, branch_o}))
        else $error("rv_decoder: more than one transfer kind");

endmodule

`default_nettype wire

//--- src/rv_id_stage.sv
`default_nettype none

module rv_id_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic [31:0]     inst_i,
    input  logic [31:0]     pc_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [31:0]     rs1_data_i,
    input  logic [31:0]     rs2_data_i,
    output logic [4:0]      rd_o,
    output logic [31:0]     rs1_data_o,
    output logic [31:0]     rs2_data_o,
    output logic [31:0]     imm_o,
    output logic [31:0]     pc_o,
    output logic            alu_src_o,
    output logic            jal_o,
    output logic            jalr_o,
    output logic            branch_o,
    output logic            bne_o,
    output logic            mem_ren_o,
    output logic            mem_wen_o,
    output logic            mem_to_reg_o,
    output logic            reg_wen_o,
    output logic            illegal_o,
    output rv_pkg::alu_op_e alu_op_o
);
    import rv_pkg::*;

    logic [4:0]      dec_rd;
    logic [XLEN-1:0] dec_imm;
    alu_op_e         dec_alu_op;
    logic            dec_alu_src, dec_jal, dec_jalr, dec_branch, dec_bne;
    logic            dec_mem_ren, dec_mem_wen, dec_mem_to_reg, dec_reg_wen, dec_illegal;
    logic [9:0]      ctrl_d;
    logic [9:0]      ctrl_q;

    rv_decoder u_decoder (
        .inst_i       (inst_i),
        .rs1_o        (rs1_addr_o),
        .rs2_o        (rs2_addr_o),
        .rd_o         (dec_rd),
        .imm_o        (dec_imm),
        .alu_src_o    (dec_alu_src),
        .jal_o        (dec_jal),
        .jalr_o       (dec_jalr),
        .branch_o     (dec_branch),
        .bne_o        (dec_bne),
        .mem_ren_o    (dec_mem_ren),
        .mem_wen_o    (dec_mem_wen),
        .mem_to_reg_o (dec_mem_to_reg),
        .reg_wen_o    (dec_reg_wen),
        .illegal_o    (dec_illegal),
        .alu_op_o     (dec_alu_op)
    );

    assign ctrl_d = {dec_alu_src, dec_jal, dec_jalr, dec_branch, dec_bne,
                     dec_mem_ren, dec_mem_wen, dec_mem_to_reg, dec_reg_wen, dec_illegal};
    assign {alu_src_o, jal_o, jalr_o, branch_o, bne_o,
            mem_ren_o, mem_wen_o, mem_to_reg_o, reg_wen_o, illegal_o} = ctrl_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_o       <= '0;
            rs1_data_o <= '0;
            rs2_data_o <= '0;
            imm_o      <= '0;
            pc_o       <= '0;
            alu_op_o   <= ALU_ADD;
            ctrl_q     <= '0;
        end else if (!stall_i) begin  // stall wins over flush.
            rs1_data_o <= rs1_data_i;
            rs2_data_o <= rs2_data_i;
            imm_o      <= dec_imm;
            pc_o       <= pc_i;
            if (flush_i) begin
                // bubble.
                rd_o     <= '0;
                alu_op_o <= ALU_ADD;
                ctrl_q   <= '0;
            end else begin
                rd_o     <= dec_rd;
                alu_op_o <= dec_alu_op;
                ctrl_q   <= ctrl_d;
            end
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ren_o && mem_wen_o))
        else $error("rv_id_stage: load and store together");

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // order is fixed, add is zero.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl and sra.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`default_nettype none

module rv_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    input  logic [4:0]  wb_rd_i,
    input  logic        wb_wen_i,
    input  logic [31:0] wb_data_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);
    import rv_pkg::*;

    localparam int AW = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [AW-1:0]   wr_idx;
    logic            wr_en;

    assign wr_idx = wb_rd_i[AW-1:0];
    assign wr_en  = wb_wen_i && (wb_rd_i != 5'd0) && (wb_rd_i < NUM_REGS);

    // x0 and out-of-range read zero, same-cycle write goes straight through.
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        logic [XLEN-1:0] val;
        val = '0;
        if (addr != 5'd0 && addr < NUM_REGS) begin
            if (wb_wen_i && addr == wb_rd_i) begin
                val = wb_data_i;
            end else begin
                val = regs[addr[AW-1:0]];
            end
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wb_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

`default_nettype wire
